//--- Makefile
# Verilator build for the timing and control core and its testbench

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_b200_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/b200_core_lite.sv
// transceiver timing and control core
// APB register block, internal PPS generator and PPS source selection

`timescale 1ns/1ps
`default_nettype none

module b200_core_lite
    import core_regmap_pkg::*;
    import pps_pkg::*;
#(
    parameter int unsigned pps_period_cycles = pps_period_default
) (
    input  wire logic                  radio_clk,
    input  wire logic                  i_arst_n,
    // APB slave
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [apb_addr_w-1:0] i_paddr,
    input  wire logic [apb_data_w-1:0] i_pwdata,
    output logic      [apb_data_w-1:0] o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    // board signals
    input  wire logic                  i_pps_gpsdo,
    input  wire logic                  i_pps_ext,
    input  wire logic [31:0]           i_rb_misc,
    output logic      [31:0]           o_misc_outs,
    output logic                       o_pps
);

    pps_src_t pps_src;
    logic     int_pps;

    core_regs core_regs_inst (
        .radio_clk   (radio_clk),
        .i_arst_n    (i_arst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .i_rb_misc   (i_rb_misc),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .o_misc_outs (o_misc_outs),
        .o_pps_src   (pps_src)
    );

    pps_generator #(
        .pps_period_cycles (pps_period_cycles)
    ) pps_generator_inst (
        .radio_clk (radio_clk),
        .i_arst_n  (i_arst_n),
        .o_pps     (int_pps)
    );

    pps_select pps_select_inst (
        .radio_clk   (radio_clk),
        .i_arst_n    (i_arst_n),
        .i_pps_gpsdo (i_pps_gpsdo),
        .i_pps_ext   (i_pps_ext),
        .i_pps_int   (int_pps),
        .i_pps_src   (pps_src),
        .o_pps       (o_pps)
    );

endmodule

`default_nettype wire

//--- source/core_regmap_pkg.sv
// core register map
// APB widths, register addresses, compat readback constants and slot names

`default_nettype none

package core_regmap_pkg;

    ////////////////////////////////////////////////////////////
    // APB bus widths
    ////////////////////////////////////////////////////////////
    localparam int unsigned apb_addr_w = 8;
    localparam int unsigned apb_data_w = 32;

    ////////////////////////////////////////////////////////////
    // register addresses
    ////////////////////////////////////////////////////////////
    localparam logic [7:0] addr_misc     = 8'h10;
    localparam logic [7:0] addr_rb_sel   = 8'h20;
    localparam logic [7:0] addr_gpsdo_st = 8'h28;
    localparam logic [7:0] addr_pps_sel  = 8'h30;
    // 64-bit readback word, low then high half
    localparam logic [7:0] addr_rb_lo    = 8'h38;
    localparam logic [7:0] addr_rb_hi    = 8'h3C;

    ////////////////////////////////////////////////////////////
    // readback content
    ////////////////////////////////////////////////////////////
    localparam logic [31:0] compat_signature = 32'hACE0BA5E;
    localparam logic [15:0] compat_major     = 16'd3;
    localparam logic [15:0] compat_minor     = 16'd0;
    // one radio fitted
    localparam logic [7:0]  radio_status     = 8'd1;

    // readback slot
    typedef enum logic [1:0] {
        rb_compat   = 2'd0,
        rb_reserved = 2'd1,
        rb_status   = 2'd2,
        rb_none     = 2'd3
    } rb_sel_t;

endpackage

`default_nettype wire

//--- source/core_regs.sv
// core register block
// APB slave with misc, readback select, GPSDO status and PPS source registers

`timescale 1ns/1ps
`default_nettype none

module core_regs
    import core_regmap_pkg::*;
    import pps_pkg::*;
(
    input  wire logic                  radio_clk,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [apb_addr_w-1:0] i_paddr,
    input  wire logic [apb_data_w-1:0] i_pwdata,
    input  wire logic [31:0]           i_rb_misc,
    output logic      [apb_data_w-1:0] o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    output logic      [31:0]           o_misc_outs,
    output pps_src_t                   o_pps_src
);

    logic [31:0]     misc_q;
    rb_sel_t         rb_sel_q;
    logic [7:0]      gpsdo_st_q;
    pps_src_t        pps_src_q;
    logic [63:0]     rb_word;
    logic [apb_data_w-1:0] acc_data;
    logic            acc_err;
    logic            acc_first;
    logic            wr_fire;

    // ready rises in the second access cycle
    assign acc_first = i_psel && i_penable && !o_pready;
    assign wr_fire   = i_psel && i_penable && o_pready && i_pwrite;

    ////////////////////////////////////////////////////////////
    // readback word
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (rb_sel_q)
            rb_compat:   rb_word = {compat_signature, compat_major, compat_minor};
            rb_reserved: rb_word = 64'd0;
            rb_status:   rb_word = {16'd0, radio_status, gpsdo_st_q, i_rb_misc};
            rb_none:     rb_word = 64'd0;
            default:     rb_word = 64'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // access decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        acc_data = '0;
        acc_err  = 1'b0;
        case (i_paddr)
            addr_misc:     acc_data = misc_q;
            addr_rb_sel:   acc_data = {30'd0, rb_sel_q};
            addr_gpsdo_st: acc_data = {24'd0, gpsdo_st_q};
            addr_pps_sel:  acc_data = {30'd0, pps_src_q};
            addr_rb_lo: begin
                acc_data = rb_word[31:0];
                acc_err  = i_pwrite;
            end
            addr_rb_hi: begin
                acc_data = rb_word[63:32];
                acc_err  = i_pwrite;
            end
            default:       acc_err = 1'b1;
        endcase
        // writes and errors return zero
        if (i_pwrite || acc_err) begin
            acc_data = '0;
        end
    end

    // handshake
    always_ff @(posedge radio_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
        end else if (acc_first) begin
            o_pready  <= 1'b1;
            o_pslverr <= acc_err;
        end else begin
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (acc_first) begin
            o_prdata <= acc_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // settings registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge radio_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            misc_q    <= 32'd0;
            rb_sel_q  <= rb_compat;
            pps_src_q <= pps_gpsdo;
        end else if (wr_fire) begin
            case (i_paddr)
                addr_misc:    misc_q    <= i_pwdata;
                addr_rb_sel:  rb_sel_q  <= rb_sel_t'(i_pwdata[1:0]);
                addr_pps_sel: pps_src_q <= pps_src_t'(i_pwdata[1:0]);
                default: begin
                end
            endcase
        end
    end

    // GPSDO status byte from software
    always_ff @(posedge radio_clk) begin
        if (wr_fire && (i_paddr == addr_gpsdo_st)) begin
            gpsdo_st_q <= i_pwdata[7:0];
        end
    end

    assign o_misc_outs = misc_q;
    assign o_pps_src   = pps_src_q;

    // ready is only raised inside an access phase
    a_pready_in_access: assert property (
        @(posedge radio_clk) disable iff (!i_arst_n)
        $rose(o_pready) |-> $past(i_psel && i_penable) && i_psel && i_penable
    );

    // error response only comes with ready and zero read data
    a_pslverr_with_pready: assert property (
        @(posedge radio_clk) disable iff (!i_arst_n)
        o_pslverr |-> o_pready && (o_prdata == '0)
    );

endmodule

`default_nettype wire

//--- source/pps_generator.sv
// internal PPS generator
// free-running counter, high for the first quarter of each period

`timescale 1ns/1ps
`default_nettype none

module pps_generator
    import pps_pkg::*;
#(
    parameter int unsigned pps_period_cycles = pps_period_default
) (
    input  wire logic radio_clk,
    input  wire logic i_arst_n,
    output logic      o_pps
);

    localparam int unsigned cnt_w = $clog2(pps_period_cycles);
    localparam logic [cnt_w-1:0] last_count = cnt_w'(pps_period_cycles - 1);
    localparam logic [cnt_w-1:0] high_count = cnt_w'(pps_period_cycles / 4);

    logic [cnt_w-1:0] cnt_q;

    always_ff @(posedge radio_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q <= '0;
            o_pps <= 1'b0;
        end else begin
            // wrap at end of period
            if (cnt_q == last_count) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            o_pps <= (cnt_q < high_count);
        end
    end

    a_count_in_period: assert property (
        @(posedge radio_clk) disable iff (!i_arst_n)
        32'(cnt_q) < pps_period_cycles
    );

endmodule

`default_nettype wire

//--- source/pps_pkg.sv
// PPS definitions
// source selector encoding and timing constants

`default_nettype none

package pps_pkg;

    // selectable PPS sources
    typedef enum logic [1:0] {
        pps_gpsdo    = 2'd0,
        pps_external = 2'd1,
        pps_internal = 2'd2,
        pps_off      = 2'd3
    } pps_src_t;

    // flops in each input synchronizer
    localparam int unsigned pps_sync_stages = 2;

    // one second at 100 MHz
    localparam int unsigned pps_period_default = 100000000;

endpackage

`default_nettype wire

//--- source/pps_select.sv
// PPS source selection
// synchronizes GPSDO and external PPS, then picks the active source

`timescale 1ns/1ps
`default_nettype none

module pps_select
    import pps_pkg::*;
(
    input  wire logic     radio_clk,
    input  wire logic     i_arst_n,
    input  wire logic     i_pps_gpsdo,
    input  wire logic     i_pps_ext,
    input  wire logic     i_pps_int,
    input  wire pps_src_t i_pps_src,
    output logic          o_pps
);

    logic [pps_sync_stages-1:0] gpsdo_sync_q;
    logic [pps_sync_stages-1:0] ext_sync_q;

    ////////////////////////////////////////////////////////////
    // input synchronizers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge radio_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            gpsdo_sync_q <= '0;
            ext_sync_q   <= '0;
        end else begin
            gpsdo_sync_q <= {gpsdo_sync_q[pps_sync_stages-2:0], i_pps_gpsdo};
            ext_sync_q   <= {ext_sync_q[pps_sync_stages-2:0], i_pps_ext};
        end
    end

    ////////////////////////////////////////////////////////////
    // source mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (i_pps_src)
            pps_gpsdo:    o_pps = gpsdo_sync_q[pps_sync_stages-1];
            pps_external: o_pps = ext_sync_q[pps_sync_stages-1];
            // generator shares the clock and needs no synchronizer
            pps_internal: o_pps = i_pps_int;
            pps_off:      o_pps = 1'b0;
            default:      o_pps = 1'b0;
        endcase
    end

    // off stays low and synchronized sources lag their pins by the sync depth
    a_src_timing: assert property (
        @(posedge radio_clk) disable iff (!i_arst_n)
        $past(i_arst_n, pps_sync_stages) |->
            o_pps == (i_pps_src == pps_gpsdo    ? $past(i_pps_gpsdo, pps_sync_stages) :
                      i_pps_src == pps_external ? $past(i_pps_ext, pps_sync_stages) :
                      i_pps_src == pps_internal ? i_pps_int : 1'b0)
    );

endmodule

`default_nettype wire

//--- sources.f
source/core_regmap_pkg.sv
source/pps_pkg.sv
source/core_regs.sv
source/pps_generator.sv
source/pps_select.sv
source/b200_core_lite.sv
verif/core_checker.sv
verif/tb_b200_core.sv

//--- verif/core_checker.sv
// scoreboard for the timing and control core
// models the register map from the APB traffic it sees and compares DUT outputs

`timescale 1ns/1ps
`default_nettype none

module core_checker
    import core_regmap_pkg::*;
    import pps_pkg::*;
#(
    parameter int unsigned pps_period_cycles = 1000
) (
    input  wire logic                  radio_clk,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_psel,
    input  wire logic                  i_penable,
    input  wire logic                  i_pwrite,
    input  wire logic [apb_addr_w-1:0] i_paddr,
    input  wire logic [apb_data_w-1:0] i_pwdata,
    input  wire logic [apb_data_w-1:0] i_prdata,
    input  wire logic                  i_pready,
    input  wire logic                  i_pslverr,
    input  wire logic                  i_pps_gpsdo,
    input  wire logic                  i_pps_ext,
    input  wire logic [31:0]           i_rb_misc,
    input  wire logic [31:0]           i_misc_outs,
    input  wire logic                  i_pps,
    output int                         o_checks,
    output int                         o_errors
);

    logic [31:0] m_misc;
    rb_sel_t     m_rb_sel;
    logic [7:0]  m_gpsdo;
    pps_src_t    m_src;
    logic [1:0]  hist_gpsdo;
    logic [1:0]  hist_ext;
    logic [32:0] exp_acc;
    logic        prev_pps = 1'b1;
    logic        seen_rise = 1'b0;
    int          since_rise = 0;
    int          phase_cycles = 0;
    int          n_checks = 0;
    int          n_errors = 0;

    assign o_checks = n_checks;
    assign o_errors = n_errors;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %s = 0x%08h, expected 0x%08h at %0t ns", name, got, exp, $time);
        end
    endtask

    // expected {pslverr, prdata} of one access under the current model
    function automatic logic [32:0] expected_access(input logic wr, input logic [7:0] addr);
        logic [63:0] word;
        logic [31:0] data;
        logic        err;
        word = 64'd0;
        if (m_rb_sel == rb_compat) begin
            word = {compat_signature, compat_major, compat_minor};
        end else if (m_rb_sel == rb_status) begin
            word = {16'd0, radio_status, m_gpsdo, i_rb_misc};
        end
        // readback words are read only
        err = (addr == addr_rb_lo || addr == addr_rb_hi) ? wr : 1'b0;
        case (addr)
            addr_misc:     data = m_misc;
            addr_rb_sel:   data = 32'(m_rb_sel);
            addr_gpsdo_st: data = 32'(m_gpsdo);
            addr_pps_sel:  data = 32'(m_src);
            addr_rb_lo:    data = word[31:0];
            addr_rb_hi:    data = word[63:32];
            default: begin
                data = 32'd0;
                err  = 1'b1;
            end
        endcase
        return {err, (wr || err) ? 32'd0 : data};
    endfunction

    always @(posedge radio_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_misc       <= 32'd0;
            m_rb_sel     <= rb_compat;
            m_src        <= pps_gpsdo;
            hist_gpsdo   <= 2'd0;
            hist_ext     <= 2'd0;
            phase_cycles = 0;
            seen_rise    = 1'b0;
            prev_pps     = 1'b1;
        end else begin
            // model and outputs change on the same edge
            compare("o_misc_outs", i_misc_outs, m_misc);

            ////////////////////////////////////////////////////////////
            // APB transfers
            ////////////////////////////////////////////////////////////
            if (i_psel && i_penable) begin
                phase_cycles++;
                if (i_pready) begin
                    exp_acc = expected_access(i_pwrite, i_paddr);
                    compare("o_prdata", i_prdata, exp_acc[31:0]);
                    compare("o_pslverr", 32'(i_pslverr), 32'(exp_acc[32]));
                    if (phase_cycles != 2) begin
                        n_errors++;
                        $display("access to 0x%02h lasted %0d cycles instead of 2",
                                 i_paddr, phase_cycles);
                    end
                    phase_cycles = 0;
                    if (i_pwrite && !exp_acc[32]) begin
                        case (i_paddr)
                            addr_misc:     m_misc   <= i_pwdata;
                            addr_rb_sel:   m_rb_sel <= rb_sel_t'(i_pwdata[1:0]);
                            addr_gpsdo_st: m_gpsdo  <= i_pwdata[7:0];
                            addr_pps_sel:  m_src    <= pps_src_t'(i_pwdata[1:0]);
                            default: begin
                            end
                        endcase
                    end
                end
            end else begin
                phase_cycles = 0;
            end

            ////////////////////////////////////////////////////////////
            // PPS output
            ////////////////////////////////////////////////////////////
            hist_gpsdo <= {hist_gpsdo[0], i_pps_gpsdo};
            hist_ext   <= {hist_ext[0], i_pps_ext};
            case (m_src)
                pps_gpsdo:    compare("o_pps", 32'(i_pps), 32'(hist_gpsdo[1]));
                pps_external: compare("o_pps", 32'(i_pps), 32'(hist_ext[1]));
                pps_off:      compare("o_pps", 32'(i_pps), 32'd0);
                default: begin
                end
            endcase
            if (m_src == pps_internal) begin
                if (seen_rise) begin
                    since_rise++;
                end
                if (i_pps && !prev_pps) begin
                    if (seen_rise) begin
                        compare("o_pps period", since_rise, pps_period_cycles);
                    end
                    since_rise = 0;
                    seen_rise  = 1'b1;
                end else if (!i_pps && prev_pps && seen_rise) begin
                    compare("o_pps high time", since_rise, pps_period_cycles / 4);
                end
                prev_pps = i_pps;
            end else begin
                // no edge counted on the first cycle after a switch
                seen_rise = 1'b0;
                prev_pps  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_b200_core.sv
// testbench for the transceiver timing and control core
// APB stimulus, random PPS pulses and the test sequence

`timescale 1ns/1ps
`default_nettype none

module tb_b200_core
    import core_regmap_pkg::*;
    import pps_pkg::*;
();

    localparam int unsigned tb_pps_period = 1000;

    logic                  radio_clk;
    logic                  arst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        pps_gpsdo;
    logic        pps_ext;
    logic [31:0] rb_misc;
    logic [31:0] misc_outs;
    logic        pps;
    logic [31:0] lfsr_state = 32'hd0b;
    logic [31:0] data;
    logic        timed_out = 1'b0;
    int          checks;
    int          errors;
    int          err_base = 0;
    int          test_num = 0;
    int          failed_tests = 0;

    always #10 radio_clk = ~radio_clk;

    b200_core_lite #(
        .pps_period_cycles (tb_pps_period)
    ) b200_core_lite_inst (
        .radio_clk   (radio_clk),
        .i_arst_n    (arst_n),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_paddr     (paddr),
        .i_pwdata    (pwdata),
        .o_prdata    (prdata),
        .o_pready    (pready),
        .o_pslverr   (pslverr),
        .i_pps_gpsdo (pps_gpsdo),
        .i_pps_ext   (pps_ext),
        .i_rb_misc   (rb_misc),
        .o_misc_outs (misc_outs),
        .o_pps       (pps)
    );

    core_checker #(
        .pps_period_cycles (tb_pps_period)
    ) core_checker_inst (
        .radio_clk   (radio_clk),
        .i_arst_n    (arst_n),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_paddr     (paddr),
        .i_pwdata    (pwdata),
        .i_prdata    (prdata),
        .i_pready    (pready),
        .i_pslverr   (pslverr),
        .i_pps_gpsdo (pps_gpsdo),
        .i_pps_ext   (pps_ext),
        .i_rb_misc   (rb_misc),
        .i_misc_outs (misc_outs),
        .i_pps       (pps),
        .o_checks    (checks),
        .o_errors    (errors)
    );

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // setup phase, access phase, then back to idle
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata);
        int wait_cnt;
        wait_cnt = 0;
        if (!timed_out) begin
            @(negedge radio_clk);
            psel    = 1'b1;
            penable = 1'b0;
            pwrite  = wr;
            paddr   = addr;
            pwdata  = wdata;
            @(negedge radio_clk);
            penable = 1'b1;
            @(negedge radio_clk);
            while (!pready && wait_cnt < 16) begin
                @(negedge radio_clk);
                wait_cnt++;
            end
            if (!pready) begin
                timed_out = 1'b1;
                $display("timeout: no o_pready on access to 0x%02h", addr);
            end
            @(negedge radio_clk);
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        apb_xfer(1'b1, addr, wdata);
    endtask

    task automatic apb_read(input logic [7:0] addr);
        apb_xfer(1'b0, addr, 32'd0);
    endtask

    // each input toggles after a random hold of 1 to 16 cycles
    task automatic drive_pulses(input int cycles);
        int          gpsdo_left;
        int          ext_left;
        logic [31:0] r;
        gpsdo_left = 0;
        ext_left   = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge radio_clk);
            if (gpsdo_left == 0) begin
                rand_bits(4, r);
                gpsdo_left = int'(r[3:0]);
                pps_gpsdo  = ~pps_gpsdo;
            end else begin
                gpsdo_left--;
            end
            if (ext_left == 0) begin
                rand_bits(4, r);
                ext_left = int'(r[3:0]);
                pps_ext  = ~pps_ext;
            end else begin
                ext_left--;
            end
        end
    endtask

    task automatic wait_pps_rises(input int rises, input int limit);
        int   seen;
        int   cycles;
        logic last;
        seen   = 0;
        cycles = 0;
        last   = pps;
        while (seen < rises && cycles < limit) begin
            @(negedge radio_clk);
            cycles++;
            if (pps && !last) begin
                seen++;
            end
            last = pps;
        end
        if (seen < rises) begin
            timed_out = 1'b1;
            $display("timeout: %0d rising edges of o_pps in %0d cycles", seen, limit);
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (errors != err_base || timed_out) begin
            failed_tests++;
            $display("test %0d %s: failed, %0d errors", test_num, name, errors - err_base);
        end else begin
            $display("test %0d %s: passed", test_num, name);
        end
        err_base = errors;
    endtask

    initial begin
        radio_clk = 1'b0;
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 8'd0;
        pwdata    = 32'd0;
        pps_gpsdo = 1'b0;
        pps_ext   = 1'b0;
        rb_misc   = 32'd0;
        repeat (16) @(negedge radio_clk);
        arst_n = 1'b1;

        apb_read(addr_misc);
        apb_read(addr_rb_sel);
        apb_read(addr_pps_sel);
        apb_read(addr_rb_lo);
        apb_read(addr_rb_hi);
        report_test("reset state");

        for (int i = 0; i < 8; i++) begin
            rand_bits(32, data);
            apb_write(addr_misc, data);
            apb_read(addr_misc);
        end
        report_test("register writes");

        rand_bits(8, data);
        apb_write(addr_gpsdo_st, data);
        apb_read(addr_gpsdo_st);
        rand_bits(32, data);
        rb_misc = data;
        for (int s = 0; s < 4; s++) begin
            apb_write(addr_rb_sel, 32'(s));
            apb_read(addr_rb_sel);
            apb_read(addr_rb_lo);
            apb_read(addr_rb_hi);
        end
        apb_write(addr_rb_sel, 32'(rb_compat));
        report_test("readback composition");

        apb_write(addr_pps_sel, 32'(pps_gpsdo));
        drive_pulses(300);
        apb_write(addr_pps_sel, 32'(pps_external));
        drive_pulses(300);
        apb_write(addr_pps_sel, 32'(pps_off));
        drive_pulses(300);
        report_test("external pps selection");

        apb_write(addr_pps_sel, 32'(pps_internal));
        wait_pps_rises(4, 6 * tb_pps_period);
        report_test("internal pps");

        rand_bits(32, data);
        apb_read(8'h00);
        apb_read(8'h44);
        apb_write(addr_rb_lo, data);
        apb_write(addr_rb_hi, data);
        apb_write(8'hFC, data);
        apb_read(addr_misc);
        apb_read(addr_rb_sel);
        apb_read(addr_gpsdo_st);
        apb_read(addr_pps_sel);
        apb_read(addr_rb_lo);
        report_test("error handling");

        repeat (2) @(negedge radio_clk);
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 test_num, failed_tests, checks, errors);
        if (timed_out || errors != 0 || failed_tests != 0 || checks == 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

`default_nettype wire
